// File: rtl/backend_consts.svh
// Backend constants
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

`define BE_XLEN        32
`define BE_AREG_W      3
`define BE_NUM_AREGS   8
`define BE_EPOCH_W     3
`define BE_OP_W        4
`define BE_SLOTS       2
`define BE_INSTR_BYTES 4
`define BE_RESET_PC    32'h0000_1000

// opcode field values, anything else runs as a nop.
`define BE_OP_ADD  4'd0
`define BE_OP_ADDI 4'd1
`define BE_OP_BEQ  4'd2
`define BE_OP_BNE  4'd3

`endif

// File: rtl/backend_pkg.sv
// Backend shared types
`default_nettype none
`include "backend_consts.svh"

package backend_pkg;

  typedef logic [`BE_XLEN-1:0] xlen_t;
  typedef logic [`BE_XLEN-1:0] pc_t;
  typedef logic [`BE_XLEN-1:0] instr_t;

  typedef logic [`BE_AREG_W-1:0]  areg_t;
  typedef logic [`BE_EPOCH_W-1:0] epoch_t;
  typedef logic [`BE_OP_W-1:0]    opcode_t;

  // index of a slot inside a fetch bundle.
  typedef logic [$clog2(`BE_SLOTS)-1:0] slot_t;

  typedef enum logic {
    CTRL_IDLE,
    CTRL_ISSUE
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/uop_if.sv
// Decoded micro-op interface
`default_nettype none

interface uop_if;
  import backend_pkg::*;

  logic    valid;
  pc_t     pc;
  pc_t     pred_npc;
  opcode_t op;
  areg_t   rd;
  areg_t   rs1;
  areg_t   rs2;
  xlen_t   imm;       // already sign-extended.
  logic    writes_rd;
  logic    is_branch;

  modport dec (
    output valid, pc, pred_npc, op, rd, rs1, rs2, imm, writes_rd, is_branch
  );

  modport rf (
    input rs1, rs2
  );

  modport ex (
    input valid, pc, pred_npc, op, rd, imm, writes_rd, is_branch
  );

endinterface

`default_nettype wire

// File: rtl/backend_ctrl.sv
// Bundle issue controller
`default_nettype none
`include "backend_consts.svh"

module backend_ctrl (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   fe_valid_i,
  output logic                                   fe_ready_o,
  input  backend_pkg::instr_t [`BE_SLOTS-1:0]    fe_instrs_i,
  input  backend_pkg::pc_t                       fe_pc_i,
  input  logic [`BE_SLOTS-1:0]                   fe_slot_valid_i,
  input  backend_pkg::pc_t [`BE_SLOTS-1:0]       fe_pred_npc_i,
  input  backend_pkg::epoch_t                    fe_epoch_i,
  input  logic                                   mispredict_i,
  output logic                                   issue_valid_o,
  output backend_pkg::instr_t                    issue_instr_o,
  output backend_pkg::pc_t                       issue_pc_o,
  output backend_pkg::pc_t                       issue_pred_npc_o
);
  import backend_pkg::*;

  ctrl_state_e             state_q;
  epoch_t                  epoch_q;
  logic [`BE_SLOTS-1:0]    pending_q;    // slots of the held bundle not yet issued.
  logic [`BE_SLOTS-1:0]    pending_rest;
  instr_t [`BE_SLOTS-1:0]  buf_instrs_q;
  pc_t [`BE_SLOTS-1:0]     buf_pred_npc_q;
  pc_t                     buf_pc_q;
  slot_t                   slot_ptr;
  logic                    fe_fire;

  assign fe_ready_o = (state_q == CTRL_IDLE);
  assign fe_fire    = fe_valid_i && fe_ready_o;

  // the lowest pending slot goes next, which keeps program order.
  always_comb begin
    slot_ptr = '0;
    for (int i = `BE_SLOTS - 1; i >= 0; i--) begin
      if (pending_q[i]) slot_ptr = slot_t'(i);
    end
    pending_rest = pending_q;
    pending_rest[slot_ptr] = 1'b0;
  end

  assign issue_valid_o    = (state_q == CTRL_ISSUE) && (|pending_q);
  assign issue_instr_o    = buf_instrs_q[slot_ptr];
  assign issue_pred_npc_o = buf_pred_npc_q[slot_ptr];
  assign issue_pc_o       = buf_pc_q + pc_t'(slot_ptr) * `BE_INSTR_BYTES;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= CTRL_IDLE;
      pending_q <= '0;
      epoch_q   <= '0;
    end else begin
      case (state_q)
        CTRL_IDLE: begin
          if (fe_fire) begin
            state_q <= CTRL_ISSUE;
            // A stale bundle is taken but leaves nothing to issue.
            pending_q <= (fe_epoch_i == epoch_q) ? fe_slot_valid_i : '0;
          end
        end
        CTRL_ISSUE: begin
          if (mispredict_i) begin
            pending_q <= '0;  // younger slots are on the wrong path.
            epoch_q   <= epoch_q + epoch_t'(1);
            state_q   <= CTRL_IDLE;
          end else begin
            pending_q <= pending_rest;
            if (pending_rest == '0) state_q <= CTRL_IDLE;
          end
        end
        default: state_q <= CTRL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fe_fire) begin
      buf_instrs_q   <= fe_instrs_i;
      buf_pred_npc_q <= fe_pred_npc_i;
      buf_pc_q       <= fe_pc_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/insn_decoder.sv
// Instruction decoder
`default_nettype none
`include "backend_consts.svh"

module insn_decoder (
  input  logic                issue_valid_i,
  input  backend_pkg::instr_t issue_instr_i,
  input  backend_pkg::pc_t    issue_pc_i,
  input  backend_pkg::pc_t    issue_pred_npc_i,
  uop_if.dec                  uop
);
  import backend_pkg::*;

  opcode_t op;
  areg_t   rd;
  logic    is_alu;

  assign op = issue_instr_i[31:28];
  assign rd = issue_instr_i[26:24];

  assign is_alu = (op == `BE_OP_ADD) || (op == `BE_OP_ADDI);

  assign uop.valid    = issue_valid_i;
  assign uop.pc       = issue_pc_i;
  assign uop.pred_npc = issue_pred_npc_i;
  assign uop.op       = op;
  assign uop.rd       = rd;
  assign uop.rs1      = issue_instr_i[22:20];
  assign uop.rs2      = issue_instr_i[18:16];

  // the immediate serves both as addend and as branch offset.
  assign uop.imm = {{(`BE_XLEN - 16){issue_instr_i[15]}}, issue_instr_i[15:0]};

  // Writes to r0 are dropped here so that commit reports we low for them.
  assign uop.writes_rd = is_alu && (rd != '0);
  assign uop.is_branch = (op == `BE_OP_BEQ) || (op == `BE_OP_BNE);

endmodule

`default_nettype wire

// File: rtl/int_regfile.sv
// Integer register file
`default_nettype none
`include "backend_consts.svh"

module int_regfile (
  input  logic                clk_i,
  input  logic                rst_n_i,
  uop_if.rf                   uop,
  input  logic                we_i,
  input  backend_pkg::areg_t  waddr_i,
  input  backend_pkg::xlen_t  wdata_i,
  output backend_pkg::xlen_t  rs1_data_o,
  output backend_pkg::xlen_t  rs2_data_o
);
  import backend_pkg::*;

  xlen_t regs_q [`BE_NUM_AREGS];

  // the commit stage writes one cycle late, so its value is bypassed.
  function automatic xlen_t read_port(areg_t addr);
    xlen_t data;
    if (addr == '0) data = '0;
    else if (we_i && (waddr_i == addr)) data = wdata_i;
    else data = regs_q[addr];
    return data;
  endfunction

  assign rs1_data_o = read_port(uop.rs1);
  assign rs2_data_o = read_port(uop.rs2);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `BE_NUM_AREGS; i++) regs_q[i] <= '0;
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
// Execute and commit stage
`default_nettype none
`include "backend_consts.svh"

module exec_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  uop_if.ex                   uop,
  input  backend_pkg::xlen_t  rs1_data_i,
  input  backend_pkg::xlen_t  rs2_data_i,
  output logic                mispredict_o,
  output logic                commit_valid_o,
  output logic                commit_we_o,
  output backend_pkg::areg_t  commit_areg_o,
  output backend_pkg::xlen_t  commit_wdata_o,
  output logic                flush_o,
  output backend_pkg::pc_t    redirect_pc_o,
  output logic                bpu_update_valid_o,
  output backend_pkg::pc_t    bpu_update_pc_o,
  output logic                bpu_update_taken_o,
  output backend_pkg::pc_t    bpu_update_target_o
);
  import backend_pkg::*;

  xlen_t alu_result;
  xlen_t src_b;
  pc_t   target;
  pc_t   actual_npc;
  logic  taken;
  logic  operands_eq;

  assign src_b       = (uop.op == `BE_OP_ADDI) ? uop.imm : rs2_data_i;
  assign alu_result  = rs1_data_i + src_b;
  assign operands_eq = (rs1_data_i == rs2_data_i);

  assign taken = ((uop.op == `BE_OP_BEQ) && operands_eq) ||
                 ((uop.op == `BE_OP_BNE) && !operands_eq);

  assign target     = uop.pc + uop.imm;
  assign actual_npc = taken ? target : uop.pc + `BE_INSTR_BYTES;

  // The controller sees this in the issue cycle and drops the younger slots.
  assign mispredict_o = uop.valid && (actual_npc != uop.pred_npc);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      commit_valid_o     <= 1'b0;
      commit_we_o        <= 1'b0;
      flush_o            <= 1'b0;
      redirect_pc_o      <= `BE_RESET_PC;
      bpu_update_valid_o <= 1'b0;
    end else begin
      commit_valid_o     <= uop.valid;
      commit_we_o        <= uop.valid && uop.writes_rd;
      flush_o            <= mispredict_o;
      redirect_pc_o      <= actual_npc;
      bpu_update_valid_o <= uop.valid && uop.is_branch;
    end
  end

  always_ff @(posedge clk_i) begin
    commit_areg_o       <= uop.rd;
    commit_wdata_o      <= alu_result;
    bpu_update_pc_o     <= uop.pc;
    bpu_update_taken_o  <= taken;
    bpu_update_target_o <= target;  // the target is reported even when not taken.
  end

endmodule

`default_nettype wire

// File: rtl/mini_backend.sv
// Mini backend top level
`default_nettype none
`include "backend_consts.svh"

module mini_backend (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 fe_valid_i,
  output logic                                 fe_ready_o,
  input  backend_pkg::instr_t [`BE_SLOTS-1:0]  fe_instrs_i,
  input  backend_pkg::pc_t                     fe_pc_i,
  input  logic [`BE_SLOTS-1:0]                 fe_slot_valid_i,
  input  backend_pkg::pc_t [`BE_SLOTS-1:0]     fe_pred_npc_i,
  input  backend_pkg::epoch_t                  fe_epoch_i,
  output logic                                 commit_valid_o,
  output logic                                 commit_we_o,
  output backend_pkg::areg_t                   commit_areg_o,
  output backend_pkg::xlen_t                   commit_wdata_o,
  output logic                                 flush_o,
  output backend_pkg::pc_t                     redirect_pc_o,
  output logic                                 bpu_update_valid_o,
  output backend_pkg::pc_t                     bpu_update_pc_o,
  output logic                                 bpu_update_taken_o,
  output backend_pkg::pc_t                     bpu_update_target_o
);
  import backend_pkg::*;

  logic   issue_valid;
  instr_t issue_instr;
  pc_t    issue_pc;
  pc_t    issue_pred_npc;
  logic   mispredict;
  xlen_t  rs1_data;
  xlen_t  rs2_data;

  uop_if uop_inst ();

  backend_ctrl ctrl_inst (
    .clk_i,
    .rst_n_i,
    .fe_valid_i,
    .fe_ready_o,
    .fe_instrs_i,
    .fe_pc_i,
    .fe_slot_valid_i,
    .fe_pred_npc_i,
    .fe_epoch_i,
    .mispredict_i     (mispredict),
    .issue_valid_o    (issue_valid),
    .issue_instr_o    (issue_instr),
    .issue_pc_o       (issue_pc),
    .issue_pred_npc_o (issue_pred_npc)
  );

  insn_decoder decoder_inst (
    .issue_valid_i    (issue_valid),
    .issue_instr_i    (issue_instr),
    .issue_pc_i       (issue_pc),
    .issue_pred_npc_i (issue_pred_npc),
    .uop              (uop_inst.dec)
  );

  // the write port is fed back from the commit register.
  int_regfile regfile_inst (
    .clk_i,
    .rst_n_i,
    .uop        (uop_inst.rf),
    .we_i       (commit_we_o),
    .waddr_i    (commit_areg_o),
    .wdata_i    (commit_wdata_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  exec_unit exec_inst (
    .clk_i,
    .rst_n_i,
    .uop          (uop_inst.ex),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .mispredict_o (mispredict),
    .commit_valid_o,
    .commit_we_o,
    .commit_areg_o,
    .commit_wdata_o,
    .flush_o,
    .redirect_pc_o,
    .bpu_update_valid_o,
    .bpu_update_pc_o,
    .bpu_update_taken_o,
    .bpu_update_target_o
  );

endmodule

`default_nettype wire

// File: dv/mini_backend_sva.sv
// Backend protocol assertions
`default_nettype none

module mini_backend_sva (
  input logic clk_i,
  input logic rst_n_i,
  input logic fe_valid_i,
  input logic fe_ready_o,
  input logic commit_valid_o,
  input logic flush_o,
  input logic bpu_update_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic accepted_q;  // set by the first bundle handshake after reset.

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      accepted_q <= 1'b0;
    end else if (fe_valid_i && fe_ready_o) begin
      accepted_q <= 1'b1;
    end
  end

  // the frontend may not withdraw a bundle before it is taken.
  valid_held_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fe_valid_i && !fe_ready_o |=> fe_valid_i)
    else $error("fe_valid_i dropped before the handshake");

  // The younger slots are dropped, so nothing commits in the cycle after a flush.
  flush_commit_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_o |-> commit_valid_o ##1 !commit_valid_o)
    else $error("flush_o without its commit, or a younger slot committed after it");

  reset_quiet_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !accepted_q |-> !flush_o && !bpu_update_valid_o && !commit_valid_o)
    else $error("commit or flush outputs active before the first bundle was accepted");

endmodule

`default_nettype wire

// File: dv/tb_mini_backend.sv
// Mini backend testbench
`default_nettype none
`include "backend_consts.svh"

module tb_mini_backend;
  timeunit 1ns;
  timeprecision 1ps;
  import backend_pkg::*;

  localparam int NUM_BUNDLES    = 300;
  localparam int TIMEOUT_CYCLES = NUM_BUNDLES * 4 + 100;

  typedef struct packed {
    areg_t areg;
    xlen_t wdata;
    logic  we;
    logic  branch;
    logic  taken;
    pc_t   pc;
    pc_t   target;
    logic  flush;
    pc_t   npc;
  } exp_commit_t;

  logic                        clk_i;
  logic                        rst_n_i;
  logic                        fe_valid_i;
  logic                        fe_ready_o;
  instr_t [`BE_SLOTS-1:0]      fe_instrs_i;
  pc_t                         fe_pc_i;
  logic [`BE_SLOTS-1:0]        fe_slot_valid_i;
  pc_t [`BE_SLOTS-1:0]         fe_pred_npc_i;
  epoch_t                      fe_epoch_i;
  logic                        commit_valid_o;
  logic                        commit_we_o;
  areg_t                       commit_areg_o;
  xlen_t                       commit_wdata_o;
  logic                        flush_o;
  pc_t                         redirect_pc_o;
  logic                        bpu_update_valid_o;
  pc_t                         bpu_update_pc_o;
  logic                        bpu_update_taken_o;
  pc_t                         bpu_update_target_o;

  xlen_t       model_regs [`BE_NUM_AREGS];
  epoch_t      model_epoch;
  logic        just_flushed;
  exp_commit_t expected_q [$];
  int          cycle_count;

  mini_backend mini_backend_inst (.*);

  bind mini_backend mini_backend_sva sva_inst (.*);

  always #2 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_commit(input areg_t areg, input xlen_t wdata, input logic we);
    if (commit_we_o !== we || commit_areg_o !== areg || (we && commit_wdata_o !== wdata))
      report_failure($sformatf(
        "** Error at %0t: commit r%0d we %0b data %0h, expected r%0d we %0b data %0h",
        $time, commit_areg_o, commit_we_o, commit_wdata_o, areg, we, wdata));
  endtask

  task automatic check_flush(input pc_t npc);
    if (flush_o !== 1'b1 || redirect_pc_o !== npc)
      report_failure($sformatf(
        "** Error at %0t: flush %0b redirect %0h, expected flush to %0h",
        $time, flush_o, redirect_pc_o, npc));
  endtask

  task automatic check_bpu(input pc_t pc, input logic taken, input pc_t target);
    if (bpu_update_valid_o !== 1'b1 || bpu_update_pc_o !== pc ||
        bpu_update_taken_o !== taken || bpu_update_target_o !== target)
      report_failure($sformatf(
        "** Error at %0t: bpu pc %0h taken %0b target %0h, expected %0h %0b %0h",
        $time, bpu_update_pc_o, bpu_update_taken_o, bpu_update_target_o, pc, taken, target));
  endtask

  // builds the next bundle and runs the reference model on its slots in order.
  task automatic build_bundle();
    exp_commit_t rec;
    instr_t      instr;
    opcode_t     op;
    xlen_t       a;
    xlen_t       b;
    xlen_t       imm;
    logic        stale;
    logic        live;
    int          r;
    stale = ($urandom_range(9) == 0) || (just_flushed && $urandom_range(1) == 0);
    fe_epoch_i = stale ? model_epoch - epoch_t'(1) : model_epoch;
    fe_pc_i = pc_t'($urandom & 32'h0000_fffc);
    live = !stale;
    just_flushed = 1'b0;
    for (int i = 0; i < `BE_SLOTS; i++) begin
      r = int'($urandom_range(9));
      op = (r < 3) ? `BE_OP_ADD : (r < 6) ? `BE_OP_ADDI : (r < 8) ? `BE_OP_BEQ :
           (r < 9) ? `BE_OP_BNE : opcode_t'(4 + $urandom_range(11));
      instr = {op, 1'b0, areg_t'($urandom_range(7)), 1'b0, areg_t'($urandom_range(3)), 1'b0,
               areg_t'($urandom_range(3)), 16'($urandom_range(31) - 16)};
      fe_instrs_i[i] = instr;
      fe_slot_valid_i[i] = ($urandom_range(7) != 0);
      a = model_regs[instr[22:20]];
      b = model_regs[instr[18:16]];
      imm = {{16{instr[15]}}, instr[15:0]};
      rec.pc = fe_pc_i + pc_t'(i * `BE_INSTR_BYTES);
      rec.areg = instr[26:24];
      rec.wdata = (op == `BE_OP_ADDI) ? a + imm : a + b;
      rec.we = (op == `BE_OP_ADD || op == `BE_OP_ADDI) && rec.areg != '0;
      rec.branch = (op == `BE_OP_BEQ || op == `BE_OP_BNE);
      rec.taken = (op == `BE_OP_BEQ) ? (a == b) : (op == `BE_OP_BNE) && (a != b);
      rec.target = rec.pc + imm;
      rec.npc = rec.taken ? rec.target : rec.pc + `BE_INSTR_BYTES;
      fe_pred_npc_i[i] = ($urandom_range(3) != 0) ? rec.npc :
                         rec.npc + pc_t'(4 * (1 + $urandom_range(3)));
      rec.flush = (fe_pred_npc_i[i] != rec.npc);
      if (live && fe_slot_valid_i[i]) begin
        expected_q.push_back(rec);
        if (rec.we) model_regs[rec.areg] = rec.wdata;
        if (rec.flush) begin
          model_epoch = model_epoch + epoch_t'(1);
          just_flushed = 1'b1;
          live = 1'b0;  // younger slots of this bundle are dropped.
        end
      end
    end
  endtask

  // outputs settle after the rising edge, so they are checked on the falling one.
  always @(negedge clk_i) begin
    exp_commit_t head;
    if (commit_valid_o === 1'b1) begin
      if (expected_q.size() == 0) begin
        report_failure("a commit appeared while no instruction was outstanding");
      end else begin
        head = expected_q.pop_front();
        check_commit(head.areg, head.wdata, head.we);
        if (head.flush) check_flush(head.npc);
        else if (flush_o !== 1'b0) report_failure("flush was raised for a correct prediction");
        if (head.branch) check_bpu(head.pc, head.taken, head.target);
        else if (bpu_update_valid_o !== 1'b0)
          report_failure("bpu update was raised for a non-branch");
      end
    end else if (flush_o !== 1'b0 || bpu_update_valid_o !== 1'b0) begin
      report_failure("flush or bpu update was raised without a commit");
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      report_failure("the run did not finish within the cycle limit");
  end

  initial begin
    void'($urandom(32'h41be));
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    cycle_count = 0;
    fe_valid_i = 1'b0;
    fe_instrs_i = '0;
    fe_pc_i = '0;
    fe_slot_valid_i = '0;
    fe_pred_npc_i = '0;
    fe_epoch_i = '0;
    model_epoch = '0;
    just_flushed = 1'b0;
    foreach (model_regs[i]) model_regs[i] = '0;
    repeat (4) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    repeat (3) @(posedge clk_i);  // quiet cycles, nothing may commit yet.
    #1;
    for (int n = 0; n < NUM_BUNDLES; n++) begin
      if ($urandom_range(7) == 0) begin
        fe_valid_i = 1'b0;
        @(posedge clk_i);
        #1;
      end
      build_bundle();
      fe_valid_i = 1'b1;
      while (fe_ready_o !== 1'b1) begin
        @(posedge clk_i);
        #1;
      end
      @(posedge clk_i);  // the bundle transfers on this edge.
      #1;
    end
    fe_valid_i = 1'b0;
    while (fe_ready_o !== 1'b1) begin
      @(posedge clk_i);
      #1;
    end
    repeat (2) @(posedge clk_i);
    #1;
    if (expected_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      report_failure("expected commits were still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: mini_backend.f
+incdir+rtl
rtl/backend_pkg.sv
rtl/uop_if.sv
rtl/backend_ctrl.sv
rtl/insn_decoder.sv
rtl/int_regfile.sv
rtl/exec_unit.sv
rtl/mini_backend.sv
dv/mini_backend_sva.sv
dv/tb_mini_backend.sv

// File: run.sh
#!/bin/sh
# Compile and run the mini backend testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv \
  --top-module tb_mini_backend --timescale 1ns/1ps \
  -Mdir obj_dir -f mini_backend.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_mini_backend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
